// File: src.f
design/rr_cfg_pkg.sv
design/rr_log_pkg.sv
design/rr_chan_logger.sv
design/rr_log_fifo.sv
design/rr_wb_writer.sv
design/rr_record_top.sv
testbench/tb_wb_mem.sv
testbench/tb_rr_record_top.sv

// File: Makefile
TOOL     := verilator
FLAGS    := --binary --timing --assert -j 0
TOP      := tb_rr_record_top
FILELIST := src.f

BUILD    := obj_dir
LOG      := sim.log
PASS_MSG := ALL TESTS PASSED

.PHONY: sim clean

# build, run and search the log for the pass line
sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

// File: testbench/tb_rr_record_top.sv
`timescale 1ns/1ps

module tb_rr_record_top
  import rr_cfg_pkg::*;
  import rr_log_pkg::*;
;

  localparam int          CLK_PERIOD  = 10;
  localparam logic [31:0] SEED        = 32'h4154c6b3;
  // idle, recording with short waits, recording with long waits
  localparam int          STIM_CYCLES = 40 + 400 + 200;

  logic                   clk;
  logic                   rstn;
  logic                   i_record_en;
  logic                   i_ocl_valid, i_ocl_ready, o_ocl_valid, o_ocl_ready;
  logic                   i_sda_valid, i_sda_ready, o_sda_valid, o_sda_ready;
  logic [CHAN_DATA_W-1:0] i_ocl_data, o_ocl_data, i_sda_data, o_sda_data;
  logic                   o_wb_cyc, o_wb_stb, o_wb_we, i_wb_ack;
  logic [WB_ADR_W-1:0]    o_wb_adr;
  logic [LOG_WORD_W-1:0]  o_wb_dat;
  logic [WB_SEL_W-1:0]    o_wb_sel;
  logic                   long_wait;
  // bus must stay quiet before the first recording
  logic                   expect_bus_idle;

  // transfers seen while recording, in happen-before order
  chan_id_e               xfer_chan[$];
  logic [CHAN_DATA_W-1:0] xfer_data[$];
  int num_queued   = 0;
  int writes_seen  = 0;
  int value_errors = 0;
  int proto_errors = 0;

  rr_record_top dut_i (.*);

  tb_wb_mem mem_i (
    .clk, .rstn, .i_long_wait(long_wait),
    .i_wb_cyc(o_wb_cyc), .i_wb_stb(o_wb_stb), .i_wb_we(o_wb_we), .i_wb_adr(o_wb_adr),
    .i_wb_dat(o_wb_dat), .i_wb_sel(o_wb_sel), .o_wb_ack(i_wb_ack)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD/2) clk = ~clk;
  end

  //////////////////////////////////////////////////
  // reference model
  //////////////////////////////////////////////////
  // k-th recorded transfer as a storage word, seq is k mod 16
  function automatic logic [LOG_WORD_W-1:0] expected_word(int k);
    logic [3:0] seq;
    seq = 4'(k % 16);
    return {4'(xfer_chan[k]), seq, xfer_data[k]};
  endfunction

  // ring slot k mod ring size, one word each
  function automatic logic [WB_ADR_W-1:0] expected_addr(int k);
    return LOG_BASE_ADDR + WB_ADR_W'(4 * (k % LOG_RING_WORDS));
  endfunction

  task automatic report_mismatch(string msg, bit on_bus);
    $display("** Error at %0d ns: %s", $time, msg);
    if (on_bus) value_errors++;
    else proto_errors++;
  endtask

  //////////////////////////////////////////////////
  // stimulus
  //////////////////////////////////////////////////
  // an offer that has not completed stays on the channel unchanged
  task automatic drive_cycle(logic rec_en, logic allow_valid);
    logic ocl_done;
    logic sda_done;
    @(negedge clk);
    ocl_done = i_ocl_valid && o_ocl_ready;
    sda_done = i_sda_valid && o_sda_ready;
    @(posedge clk);
    #1;
    i_record_en = rec_en;
    if (!i_ocl_valid || ocl_done) begin
      i_ocl_valid = allow_valid && ($urandom_range(3, 0) != 0);
      i_ocl_data  = CHAN_DATA_W'($urandom);
    end
    if (!i_sda_valid || sda_done) begin
      i_sda_valid = allow_valid && ($urandom_range(3, 0) != 0);
      i_sda_data  = CHAN_DATA_W'($urandom);
    end
    i_ocl_ready = ($urandom_range(3, 0) != 0);
    i_sda_ready = ($urandom_range(3, 0) != 0);
  endtask

  task automatic run_phase(int n, logic rec_en, logic slow);
    long_wait = slow;
    repeat (n) drive_cycle(rec_en, 1'b1);
  endtask

  initial begin
    void'($urandom(SEED));
    rstn            = 1'b0;
    i_record_en     = 1'b0;
    i_ocl_valid     = 1'b0;
    i_ocl_data      = '0;
    i_ocl_ready     = 1'b0;
    i_sda_valid     = 1'b0;
    i_sda_data      = '0;
    i_sda_ready     = 1'b0;
    long_wait       = 1'b0;
    expect_bus_idle = 1'b0;
    repeat (2) @(posedge clk);
    #1;
    rstn = 1'b1;
    @(negedge clk);
    assert (!o_wb_cyc && !o_wb_stb) else report_mismatch("bus request after reset", 1'b1);
    expect_bus_idle = 1'b1;
    run_phase(40, 1'b0, 1'b0);
    expect_bus_idle = 1'b0;
    run_phase(400, 1'b1, 1'b0);
    run_phase(200, 1'b1, 1'b1);
    // no new offers, pending ones still complete while recording
    while (i_ocl_valid || i_sda_valid) drive_cycle(1'b1, 1'b0);
    drive_cycle(1'b0, 1'b0);
    while (writes_seen < num_queued) @(posedge clk);
    repeat (20) @(posedge clk);
    assert (writes_seen == num_queued) else
      report_mismatch($sformatf("%0d writes for %0d transfers", writes_seen, num_queued), 1'b1);
    // last lap of the ring holds the newest entries
    for (int k = (num_queued > LOG_RING_WORDS) ? num_queued - LOG_RING_WORDS : 0;
         k < num_queued; k++) begin
      assert (mem_i.mem[k % LOG_RING_WORDS] == expected_word(k)) else
        report_mismatch($sformatf("ring slot %0d holds %h, expected %h", k % LOG_RING_WORDS,
                                  mem_i.mem[k % LOG_RING_WORDS], expected_word(k)), 1'b1);
    end
    if (num_queued <= LOG_RING_WORDS) begin
      $display("too few transfers recorded to wrap the storage ring");
      proto_errors++;
    end
    $display("%0d transfers, %0d writes, %0d value errors, %0d protocol errors",
             num_queued, writes_seen, value_errors, proto_errors);
    if (value_errors == 0 && proto_errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

  //////////////////////////////////////////////////
  // monitor and compare
  //////////////////////////////////////////////////
  // sampled mid cycle, inputs and registers are settled
  always @(negedge clk) begin
    logic ocl_fire;
    logic sda_fire;
    ocl_fire = i_ocl_valid && o_ocl_ready;
    sda_fire = i_sda_valid && o_sda_ready;
    if (rstn) begin
      assert (o_ocl_valid == i_ocl_valid && o_ocl_data == i_ocl_data) else
        report_mismatch("ocl pass-through differs", 1'b0);
      assert (o_sda_valid == i_sda_valid && o_sda_data == i_sda_data) else
        report_mismatch("sda pass-through differs", 1'b0);
      assert (!expect_bus_idle || !o_wb_cyc) else
        report_mismatch("storage write with recording off", 1'b1);
      if (!i_record_en) begin
        assert (o_ocl_ready == i_ocl_ready && o_sda_ready == i_sda_ready) else
          report_mismatch("ready not passed through with recording off", 1'b0);
      end else begin
        assert (!(ocl_fire && sda_fire)) else
          report_mismatch("ocl and sda transfers in the same cycle", 1'b0);
        if (ocl_fire) begin
          xfer_chan.push_back(CHAN_OCL);
          xfer_data.push_back(i_ocl_data);
          num_queued++;
        end
        if (sda_fire) begin
          xfer_chan.push_back(CHAN_SDA);
          xfer_data.push_back(i_sda_data);
          num_queued++;
        end
      end
    end
  end

  // each acked write against the next expected entry
  always @(negedge clk) begin
    if (rstn && o_wb_cyc && o_wb_stb && i_wb_ack) begin
      if (writes_seen >= num_queued) begin
        report_mismatch("storage write without a recorded transfer", 1'b1);
      end else begin
        assert (o_wb_dat == expected_word(writes_seen)) else
          report_mismatch($sformatf("word %0d data %h, expected %h", writes_seen,
                                    o_wb_dat, expected_word(writes_seen)), 1'b1);
        assert (o_wb_adr == expected_addr(writes_seen)) else
          report_mismatch($sformatf("word %0d address %h, expected %h", writes_seen,
                                    o_wb_adr, expected_addr(writes_seen)), 1'b1);
        assert (o_wb_we && o_wb_sel == '1) else
          report_mismatch($sformatf("word %0d we or sel wrong", writes_seen), 1'b1);
      end
      writes_seen++;
    end
  end

  // limit grows with the recorded traffic, 40 cycles per transfer
  initial begin
    int cycles;
    cycles = 0;
    while (cycles <= STIM_CYCLES + 40 * (num_queued + 1)) begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout: run still busy after %0d cycles, %0d of %0d entries written",
             cycles, writes_seen, num_queued);
    $display("SOME TESTS FAILED");
    $finish;
  end

endmodule

// File: testbench/tb_wb_mem.sv
`timescale 1ns/1ps

module tb_wb_mem
  import rr_cfg_pkg::*;
(
  input  logic                  clk,
  input  logic                  rstn,
  // long wait states hold the writer for many cycles
  input  logic                  i_long_wait,
  input  logic                  i_wb_cyc,
  input  logic                  i_wb_stb,
  input  logic                  i_wb_we,
  input  logic [WB_ADR_W-1:0]   i_wb_adr,
  input  logic [LOG_WORD_W-1:0] i_wb_dat,
  input  logic [WB_SEL_W-1:0]   i_wb_sel,
  output logic                  o_wb_ack
);

  // trace storage, one word per ring slot
  logic [LOG_WORD_W-1:0] mem [LOG_RING_WORDS];
  logic                  busy_q;
  int                    wait_q;

  // byte address to ring slot
  function automatic int ring_word(logic [WB_ADR_W-1:0] adr);
    return int'((adr - LOG_BASE_ADDR) >> 2) % LOG_RING_WORDS;
  endfunction

  always @(posedge clk) begin
    if (!rstn) begin
      o_wb_ack <= 1'b0;
      busy_q   <= 1'b0;
      wait_q   <= 0;
    end else if (o_wb_ack) begin
      // single write ends here
      o_wb_ack <= 1'b0;
      busy_q   <= 1'b0;
    end else if (i_wb_cyc && i_wb_stb) begin
      if (!busy_q) begin
        busy_q <= 1'b1;
        wait_q <= i_long_wait ? int'($urandom_range(20, 8)) : int'($urandom_range(2, 0));
      end else if (wait_q == 0) begin
        o_wb_ack <= 1'b1;
        if (i_wb_we) begin
          for (int b = 0; b < WB_SEL_W; b++) begin
            if (i_wb_sel[b]) mem[ring_word(i_wb_adr)][8*b +: 8] <= i_wb_dat[8*b +: 8];
          end
        end
      end else begin
        wait_q <= wait_q - 1;
      end
    end
  end

endmodule

// File: design/rr_record_top.sv
`timescale 1ns/1ps

module rr_record_top
  import rr_cfg_pkg::*;
  import rr_log_pkg::*;
(
  input  logic                   clk,
  input  logic                   rstn,
  input  logic                   i_record_en,
  // ocl, shell side then CL side
  input  logic                   i_ocl_valid,
  input  logic [CHAN_DATA_W-1:0] i_ocl_data,
  output logic                   o_ocl_ready,
  output logic                   o_ocl_valid,
  output logic [CHAN_DATA_W-1:0] o_ocl_data,
  input  logic                   i_ocl_ready,
  // sda, shell side then CL side
  input  logic                   i_sda_valid,
  input  logic [CHAN_DATA_W-1:0] i_sda_data,
  output logic                   o_sda_ready,
  output logic                   o_sda_valid,
  output logic [CHAN_DATA_W-1:0] o_sda_data,
  input  logic                   i_sda_ready,
  // trace storage write port
  output logic                   o_wb_cyc,
  output logic                   o_wb_stb,
  output logic                   o_wb_we,
  output logic [WB_ADR_W-1:0]    o_wb_adr,
  output logic [LOG_WORD_W-1:0]  o_wb_dat,
  output logic [WB_SEL_W-1:0]    o_wb_sel,
  input  logic                   i_wb_ack
);

  //////////////////////////////////////////////////
  // logger to buffer, buffer to writer
  //////////////////////////////////////////////////
  logic       log_valid;
  logic       log_ready;
  log_entry_t log_entry;
  logic       wr_valid;
  logic       wr_ready;
  log_entry_t wr_entry;

  rr_chan_logger logger_i (
    .clk, .rstn, .i_record_en,
    .i_ocl_valid, .i_ocl_data, .o_ocl_ready, .o_ocl_valid, .o_ocl_data, .i_ocl_ready,
    .i_sda_valid, .i_sda_data, .o_sda_ready, .o_sda_valid, .o_sda_data, .i_sda_ready,
    .o_log_valid(log_valid), .i_log_ready(log_ready), .o_log_entry(log_entry)
  );

  rr_log_fifo #(.DEPTH(FIFO_DEPTH)) fifo_i (
    .clk, .rstn,
    .i_push_valid(log_valid), .o_push_ready(log_ready), .i_push_entry(log_entry),
    .o_pop_valid(wr_valid), .i_pop_ready(wr_ready), .o_pop_entry(wr_entry)
  );

  rr_wb_writer writer_i (
    .clk, .rstn,
    .i_entry_valid(wr_valid), .o_entry_ready(wr_ready), .i_entry(wr_entry),
    .o_wb_cyc, .o_wb_stb, .o_wb_we, .o_wb_adr, .o_wb_dat, .o_wb_sel, .i_wb_ack
  );

endmodule

// File: design/rr_wb_writer.sv
`timescale 1ns/1ps

module rr_wb_writer
  import rr_cfg_pkg::*;
  import rr_log_pkg::*;
(
  input  logic                  clk,
  input  logic                  rstn,
  // entries from the buffer
  input  logic                  i_entry_valid,
  output logic                  o_entry_ready,
  input  log_entry_t            i_entry,
  // wishbone classic master, write only
  output logic                  o_wb_cyc,
  output logic                  o_wb_stb,
  output logic                  o_wb_we,
  output logic [WB_ADR_W-1:0]   o_wb_adr,
  output logic [LOG_WORD_W-1:0] o_wb_dat,
  output logic [WB_SEL_W-1:0]   o_wb_sel,
  input  logic                  i_wb_ack
);

  typedef enum logic {
    ST_IDLE,
    ST_WRITE
  } wr_state_e;

  wr_state_e             state_q;
  // entry held for the whole bus cycle
  log_entry_t            dat_q;
  logic [RING_IDX_W-1:0] idx_q;
  logic                  take;

  //////////////////////////////////////////////////
  // entry intake
  //////////////////////////////////////////////////
  // one entry per bus cycle, taken only in idle
  assign o_entry_ready = (state_q == ST_IDLE);
  assign take          = i_entry_valid && o_entry_ready;

  always_ff @(posedge clk) begin
    if (take) begin
      dat_q <= i_entry;
    end
  end

  //////////////////////////////////////////////////
  // bus FSM and ring index
  //////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (!rstn) begin
      state_q <= ST_IDLE;
      idx_q   <= '0;
    end else begin
      case (state_q)
        ST_IDLE: begin
          if (take) state_q <= ST_WRITE;
        end
        ST_WRITE: begin
          // write done, next word of the ring
          if (i_wb_ack) begin
            state_q <= ST_IDLE;
            if (idx_q == RING_IDX_W'(LOG_RING_WORDS - 1)) begin
              idx_q <= '0;
            end else begin
              idx_q <= idx_q + 1'b1;
            end
          end
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  // bus outputs straight from the state
  assign o_wb_cyc = (state_q == ST_WRITE);
  assign o_wb_stb = (state_q == ST_WRITE);
  assign o_wb_we  = (state_q == ST_WRITE);
  assign o_wb_sel = '1;
  assign o_wb_dat = dat_q;
  // word index to byte address
  assign o_wb_adr = LOG_BASE_ADDR + {{(WB_ADR_W-RING_IDX_W-2){1'b0}}, idx_q, 2'b00};

  // request held steady until the slave acks
  a_req_stable : assert property (
    @(posedge clk) disable iff (!rstn)
    (o_wb_stb && !i_wb_ack) |=> (o_wb_stb && $stable(o_wb_adr) && $stable(o_wb_dat)));
  a_ack_in_cycle : assert property (
    @(posedge clk) disable iff (!rstn) i_wb_ack |-> o_wb_stb);

endmodule

// File: design/rr_log_fifo.sv
`timescale 1ns/1ps

module rr_log_fifo
  import rr_cfg_pkg::*;
  import rr_log_pkg::*;
#(
  // power of two, at least 2
  parameter int DEPTH = FIFO_DEPTH
) (
  input  logic       clk,
  input  logic       rstn,
  input  logic       i_push_valid,
  output logic       o_push_ready,
  input  log_entry_t i_push_entry,
  output logic       o_pop_valid,
  input  logic       i_pop_ready,
  output log_entry_t o_pop_entry
);

  localparam int AW = $clog2(DEPTH);

  log_entry_t    mem [DEPTH];
  logic [AW-1:0] wptr_q;
  logic [AW-1:0] rptr_q;
  logic [AW:0]   count_q;
  logic          full;
  logic          push;
  logic          pop;

  //////////////////////////////////////////////////
  // handshake
  //////////////////////////////////////////////////
  assign full         = (count_q == (AW+1)'(DEPTH));
  assign o_pop_valid  = (count_q != '0);
  assign pop          = o_pop_valid && i_pop_ready;
  // a pop frees a slot in the same cycle
  assign o_push_ready = !full || pop;
  assign push         = i_push_valid && o_push_ready;
  assign o_pop_entry  = mem[rptr_q];

  // storage array
  always_ff @(posedge clk) begin
    if (push) begin
      mem[wptr_q] <= i_push_entry;
    end
  end

  // pointers wrap naturally with DEPTH a power of two
  always_ff @(posedge clk) begin
    if (!rstn) begin
      wptr_q  <= '0;
      rptr_q  <= '0;
      count_q <= '0;
    end else begin
      if (push) wptr_q <= wptr_q + 1'b1;
      if (pop)  rptr_q <= rptr_q + 1'b1;
      if (push && !pop) begin
        count_q <= count_q + 1'b1;
      end else if (pop && !push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  // producer never offers an entry to a full buffer without a pop
  a_no_overflow : assert property (
    @(posedge clk) disable iff (!rstn) i_push_valid |-> o_push_ready);
  // count stays within DEPTH and matches the pointer distance
  a_count_consistent : assert property (
    @(posedge clk) disable iff (!rstn)
    (count_q <= (AW+1)'(DEPTH)) && (AW'(wptr_q - rptr_q) == count_q[AW-1:0]));

endmodule

// File: design/rr_chan_logger.sv
`timescale 1ns/1ps

module rr_chan_logger
  import rr_cfg_pkg::*;
  import rr_log_pkg::*;
(
  input  logic                   clk,
  input  logic                   rstn,
  input  logic                   i_record_en,
  // ocl channel
  input  logic                   i_ocl_valid,
  input  logic [CHAN_DATA_W-1:0] i_ocl_data,
  output logic                   o_ocl_ready,
  output logic                   o_ocl_valid,
  output logic [CHAN_DATA_W-1:0] o_ocl_data,
  input  logic                   i_ocl_ready,
  // sda channel
  input  logic                   i_sda_valid,
  input  logic [CHAN_DATA_W-1:0] i_sda_data,
  output logic                   o_sda_ready,
  output logic                   o_sda_valid,
  output logic [CHAN_DATA_W-1:0] o_sda_data,
  input  logic                   i_sda_ready,
  // log entries towards the buffer
  output logic                   o_log_valid,
  input  logic                   i_log_ready,
  output log_entry_t             o_log_entry
);

  // round-robin state, high when sda has priority
  logic             prio_sda_q;
  logic [SEQ_W-1:0] seq_q;
  logic             gnt_ocl;
  logic             gnt_sda;
  logic             ocl_fire;
  logic             sda_fire;

  // shell to CL forward path is untouched
  assign o_ocl_valid = i_ocl_valid;
  assign o_ocl_data  = i_ocl_data;
  assign o_sda_valid = i_sda_valid;
  assign o_sda_data  = i_sda_data;

  //////////////////////////////////////////////////
  // grant and ready gating
  //////////////////////////////////////////////////
  // priority channel wins, the other one only when priority side is idle
  assign gnt_ocl = i_ocl_valid && (!prio_sda_q || !i_sda_valid);
  assign gnt_sda = i_sda_valid && !gnt_ocl;

  // no buffer space means no transfer while recording
  assign o_ocl_ready = i_record_en ? (i_ocl_ready && gnt_ocl && i_log_ready) : i_ocl_ready;
  assign o_sda_ready = i_record_en ? (i_sda_ready && gnt_sda && i_log_ready) : i_sda_ready;

  assign ocl_fire = i_record_en && i_ocl_valid && o_ocl_ready;
  assign sda_fire = i_record_en && i_sda_valid && o_sda_ready;

  //////////////////////////////////////////////////
  // entry formation, same cycle as the transfer
  //////////////////////////////////////////////////
  assign o_log_valid = ocl_fire || sda_fire;

  always_comb begin
    o_log_entry.chan    = ocl_fire ? CHAN_OCL : CHAN_SDA;
    o_log_entry.seq     = seq_q;
    o_log_entry.payload = ocl_fire ? i_ocl_data : i_sda_data;
  end

  // priority flips to the channel that was not just logged
  always_ff @(posedge clk) begin
    if (!rstn) begin
      prio_sda_q <= 1'b0;
      seq_q      <= '0;
    end else if (o_log_valid) begin
      prio_sda_q <= ocl_fire;
      // wraps at 16 on its own
      seq_q      <= seq_q + 1'b1;
    end
  end

  // a held-back shell offer keeps its payload until it transfers
  a_ocl_offer_held : assert property (
    @(posedge clk) disable iff (!rstn)
    (i_ocl_valid && !o_ocl_ready) |=> (i_ocl_valid && $stable(i_ocl_data)));
  a_sda_offer_held : assert property (
    @(posedge clk) disable iff (!rstn)
    (i_sda_valid && !o_sda_ready) |=> (i_sda_valid && $stable(i_sda_data)));

endmodule

// File: design/rr_log_pkg.sv
package rr_log_pkg;

  import rr_cfg_pkg::*;

  // width of the happen-before sequence number
  localparam int SEQ_W = 4;

  // channel id stored in the top nibble of an entry
  typedef enum logic [3:0] {
    CHAN_OCL = 4'd1,
    CHAN_SDA = 4'd2
  } chan_id_e;

  //////////////////////////////////////////////////
  // log entry layout, msb first
  //////////////////////////////////////////////////
  typedef struct packed {
    chan_id_e                chan;
    logic [SEQ_W-1:0]        seq;
    logic [CHAN_DATA_W-1:0]  payload;
  } log_entry_t;

endpackage

// File: design/rr_cfg_pkg.sv
package rr_cfg_pkg;

  //////////////////////////////////////////////////
  // channel and log word sizes
  //////////////////////////////////////////////////
  // register-access payload carried by ocl and sda
  localparam int CHAN_DATA_W = 24;
  // one log entry is one storage word
  localparam int LOG_WORD_W = 32;

  //////////////////////////////////////////////////
  // trace storage
  //////////////////////////////////////////////////
  localparam int WB_ADR_W = 32;
  // byte lanes of a storage word
  localparam int WB_SEL_W = LOG_WORD_W / 8;
  // byte address of ring word 0
  localparam logic [WB_ADR_W-1:0] LOG_BASE_ADDR = 32'h0000_1000;
  localparam int LOG_RING_WORDS = 64;
  localparam int RING_IDX_W = $clog2(LOG_RING_WORDS);

  // entries buffered between logger and storage writer
  localparam int FIFO_DEPTH = 8;

endpackage
